// File: Makefile
TOP = renameTb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "CHECKS FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "Simulation failed"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

// File: all.f
renamePkg.sv
creditFifo.sv
renameTable.sv
tagFreeList.sv
renameStage.sv
renameTop.sv
renameCheck_asserts.sv
renameTb.sv

// File: creditFifo.sv
`timescale 1ns/10ps
`default_nettype none

module creditFifo #(
    parameter type T = logic [7:0],
    parameter int DEPTH = 4,
    // Set when the consumer's credit pulse is itself the pop request
    parameter bit CONSUMER_POP = 1'b0
) (
    input logic clk,
    input logic rst,
    input logic flush,
    input logic pushValid,
    input T pushData,
    output logic creditOut,
    output logic outValid,
    output T outData,
    input logic creditIn
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] credits;
    logic pop;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign outValid = (count != '0) && (credits != '0) && !flush;
    assign outData = mem[rdPtr];
    assign pop = outValid && (CONSUMER_POP ? creditIn : 1'b1);
    assign creditOut = pop;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            credits <= CNT_W'(DEPTH);
        end else begin
            if (pushValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            count <= count + CNT_W'(pushValid) - CNT_W'(pop);
            credits <= credits + CNT_W'(creditIn) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (pushValid) begin
            mem[wrPtr] <= pushData;
        end
    end

endmodule

`default_nettype wire

// File: renameCheck_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module renameCheck (
    input logic clk,
    input logic rst,
    input logic flush,
    input logic renValid,
    input logic dispCredit,
    input logic [renamePkg::TAG_W-1:0] specHead,
    input logic [renamePkg::TAG_W-1:0] comHead,
    input logic allocValid,
    input logic stagePush,
    input logic [$clog2(renamePkg::OUT_DEPTH + 1)-1:0] outCount
);

    import renamePkg::*;

    localparam int CRED_W = $clog2(OUT_DEPTH + 1);

    logic [CRED_W-1:0] dispCredits;
    logic [TAG_W-1:0] held;

    // Dispatch's own credit count, rebuilt from the port handshake
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            dispCredits <= CRED_W'(OUT_DEPTH);
        end else begin
            dispCredits <= dispCredits + CRED_W'(dispCredit) - CRED_W'(renValid);
        end
    end

    // Tags taken by micro-ops that have not committed yet
    assign held = specHead - comHead;

    // Output buffer hands a micro-op to dispatch only against a credit
    noDispCredit: assert property (@(posedge clk) disable iff (rst)
        renValid |-> dispCredits != '0)
        else $error("renValid raised with zero dispatch credits");

    // Only 32 tags lie free beyond the committed head
    allocWhenEmpty: assert property (@(posedge clk) disable iff (rst)
        allocValid |-> held < TAG_W'(NUM_ARCH_REGS))
        else $error("tag allocated while the free list is empty");

    // Stage credits, buffered entries and the pending push add up to the depth
    noStageCredit: assert property (@(posedge clk) disable iff (rst)
        stagePush |-> outCount != CRED_W'(OUT_DEPTH))
        else $error("rename stage pushed into a full output buffer");

endmodule

bind renameTop renameCheck check_i (
    .clk(clk), .rst(rst), .flush(flush.valid), .renValid(renValid),
    .dispCredit(dispCredit), .specHead(freeList_i.specHead),
    .comHead(freeList_i.comHead), .allocValid(allocValid), .stagePush(stagePush),
    .outCount(outBuf_i.count)
);

`default_nettype wire

// File: renamePkg.sv
`default_nettype none

package renamePkg;

    // Register file and tag space
    localparam int NUM_ARCH_REGS = 32;
    localparam int NUM_TAGS = 64;
    localparam int TAG_W = 6;
    localparam int REG_W = 5;

    // Buffer depths, also the initial credit counts of each producer
    localparam int IN_DEPTH = 4;
    localparam int OUT_DEPTH = 4;

    // Micro-op as it leaves the decoder
    typedef struct packed {
        logic [REG_W-1:0] rs0;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rd;
        logic [7:0] opcode;
        logic [31:0] imm;
    } DecUop;

    // Micro-op after renaming
    typedef struct packed {
        logic [TAG_W-1:0] sqN;
        logic [TAG_W-1:0] tagA;
        logic [TAG_W-1:0] tagB;
        logic availA;
        logic availB;
        // Zero when nmDst is zero
        logic [TAG_W-1:0] tagDst;
        logic [REG_W-1:0] nmDst;
        logic [7:0] opcode;
        logic [31:0] imm;
    } RenUop;

    typedef struct packed {
        logic valid;
        logic [TAG_W-1:0] tag;
    } WbPort;

    typedef struct packed {
        logic valid;
        logic [REG_W-1:0] nmDst;
        logic [TAG_W-1:0] tagDst;
    } CommitPort;

    // sqN is the last surviving micro-op
    typedef struct packed {
        logic valid;
        logic [TAG_W-1:0] sqN;
    } FlushPort;

endpackage

`default_nettype wire

// File: renameStage.sv
`timescale 1ns/10ps
`default_nettype none

module renameStage (
    input logic clk,
    input logic rst,
    input logic inValid,
    input renamePkg::DecUop inUop,
    output logic pop,
    output logic outPush,
    output renamePkg::RenUop outUop,
    input logic outCredit,
    output logic [renamePkg::REG_W-1:0] lookupA,
    output logic [renamePkg::REG_W-1:0] lookupB,
    input logic [renamePkg::TAG_W-1:0] tagA,
    input logic [renamePkg::TAG_W-1:0] tagB,
    input logic availA,
    input logic availB,
    output logic [renamePkg::REG_W-1:0] allocReg,
    output logic allocValid,
    input logic [renamePkg::TAG_W-1:0] allocTag,
    input logic freeEmpty,
    input renamePkg::FlushPort flush
);

    import renamePkg::*;

    localparam int CRED_W = $clog2(OUT_DEPTH + 1);

    logic [CRED_W-1:0] credits;
    logic [TAG_W-1:0] nextSqN;
    logic hasDst;
    logic fire;

    assign hasDst = (inUop.rd != '0);

    // A micro-op without a destination does not need a free tag
    assign fire = inValid && (credits != '0) && (!freeEmpty || !hasDst) && !flush.valid;

    assign pop = fire;
    assign lookupA = inUop.rs0;
    assign lookupB = inUop.rs1;
    assign allocReg = inUop.rd;
    assign allocValid = fire && hasDst;

    // Credit is spent at fire, the push follows a cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CRED_W'(OUT_DEPTH);
            nextSqN <= '0;
            outPush <= 1'b0;
        end else if (flush.valid) begin
            credits <= CRED_W'(OUT_DEPTH);
            nextSqN <= flush.sqN + 1'b1;
            outPush <= 1'b0;
        end else begin
            credits <= credits + CRED_W'(outCredit) - CRED_W'(fire);
            outPush <= fire;
            if (fire) begin
                nextSqN <= nextSqN + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            outUop.sqN <= nextSqN;
            outUop.tagA <= tagA;
            outUop.tagB <= tagB;
            outUop.availA <= availA;
            outUop.availB <= availB;
            outUop.tagDst <= hasDst ? allocTag : '0;
            outUop.nmDst <= inUop.rd;
            outUop.opcode <= inUop.opcode;
            outUop.imm <= inUop.imm;
        end
    end

endmodule

`default_nettype wire

// File: renameTable.sv
`timescale 1ns/10ps
`default_nettype none

module renameTable (
    input logic clk,
    input logic rst,
    input logic [renamePkg::REG_W-1:0] lookupA,
    input logic [renamePkg::REG_W-1:0] lookupB,
    input logic [renamePkg::REG_W-1:0] allocReg,
    input logic allocValid,
    input logic [renamePkg::TAG_W-1:0] allocTag,
    output logic [renamePkg::TAG_W-1:0] tagA,
    output logic [renamePkg::TAG_W-1:0] tagB,
    output logic availA,
    output logic availB,
    input renamePkg::WbPort wb,
    input renamePkg::CommitPort commit,
    output logic [renamePkg::TAG_W-1:0] prevTag,
    input renamePkg::FlushPort flush
);

    import renamePkg::*;

    logic [TAG_W-1:0] specMap [NUM_ARCH_REGS];
    logic [TAG_W-1:0] comMap [NUM_ARCH_REGS];
    logic [NUM_TAGS-1:0] ready;
    logic comWrite;

    assign comWrite = commit.valid && (commit.nmDst != '0);

    // r0 is hardwired to tag 0 and always available
    always_comb begin
        if (lookupA == '0) begin
            tagA = '0;
            availA = 1'b1;
        end else begin
            tagA = specMap[lookupA];
            availA = ready[tagA] || (wb.valid && (wb.tag == tagA));
        end
    end

    always_comb begin
        if (lookupB == '0) begin
            tagB = '0;
            availB = 1'b1;
        end else begin
            tagB = specMap[lookupB];
            availB = ready[tagB] || (wb.valid && (wb.tag == tagB));
        end
    end

    // Old committed mapping goes back to the free list
    assign prevTag = comMap[commit.nmDst];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                specMap[r] <= TAG_W'(r);
                comMap[r] <= TAG_W'(r);
            end
        end else begin
            if (comWrite) begin
                comMap[commit.nmDst] <= commit.tagDst;
            end
            if (flush.valid) begin
                for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                    specMap[r] <= comMap[r];
                end
                // Commit in the flush cycle still counts
                if (comWrite) begin
                    specMap[commit.nmDst] <= commit.tagDst;
                end
            end else if (allocValid) begin
                specMap[allocReg] <= allocTag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready <= {{(NUM_TAGS - NUM_ARCH_REGS){1'b0}}, {NUM_ARCH_REGS{1'b1}}};
        end else begin
            if (wb.valid) begin
                ready[wb.tag] <= 1'b1;
            end
            if (allocValid) begin
                ready[allocTag] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: renameTb.sv
`timescale 1ns/10ps
`default_nettype none

module renameTb;

    import renamePkg::*;

    localparam int DRAIN_CYCLES = 100;
    localparam int TOTAL_CYCLES = 1520 + 6 * DRAIN_CYCLES;

    logic clk;
    logic rst;
    logic decValid;
    DecUop decUop;
    logic decCredit;
    logic renValid;
    RenUop renUop;
    logic dispCredit;
    WbPort wb;
    CommitPort commit;
    FlushPort flush;

    logic [31:0] lfsr;
    logic [TAG_W-1:0] specMap [NUM_ARCH_REGS];
    logic [TAG_W-1:0] comMap [NUM_ARCH_REGS];
    logic rdy [NUM_TAGS];
    logic [TAG_W-1:0] freeQ [$];
    logic [TAG_W-1:0] pendWb [$];
    DecUop inQ [$];
    RenUop expQ [$];
    RenUop robQ [$];
    int specIdx;
    logic [TAG_W-1:0] seq;
    logic [TAG_W-1:0] lastSq;
    int decCredits;
    int dispCnt;
    int owed;
    int errors;
    int checks;
    int testErrors;
    int numTests;
    string curTest;

    renameTop renameTop_i (
        .clk(clk), .rst(rst), .decValid(decValid), .decUop(decUop), .decCredit(decCredit),
        .renValid(renValid), .renUop(renUop), .dispCredit(dispCredit), .wb(wb),
        .commit(commit), .flush(flush)
    );

    // Galois LFSR, one step per random bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // True with probability n/64
    function automatic logic chance(input int n);
        return int'(randBits(6)) < n;
    endfunction

    task automatic check(input string what, input logic [127:0] expected,
                         input logic [127:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            testErrors++;
            $display("Error %s %s: expected %h, actual %h", curTest, what, expected, actual);
        end
    endtask

    task automatic report(input string msg);
        errors++;
        testErrors++;
        $display("%s: %s", curTest, msg);
    endtask

    task automatic driveInputs(input int pushRate, input int wbRate, input int comRate,
                               input int flushRate, input int dispRate);
        int k;
        decValid = 1'b0;
        wb = '0;
        commit = '0;
        flush = '0;
        dispCredit = 1'b0;
        if (flushRate > 0 && chance(flushRate)) begin
            flush.valid = 1'b1;
            flush.sqN = lastSq;
            return;
        end
        if (decCredits > 0 && chance(pushRate)) begin
            decValid = 1'b1;
            decCredits--;
            decUop.rs0 = REG_W'(randBits(REG_W));
            decUop.rs1 = REG_W'(randBits(REG_W));
            decUop.rd = chance(6) ? '0 : REG_W'(randBits(REG_W));
            decUop.opcode = 8'(randBits(8));
            decUop.imm = randBits(32);
        end
        if (pendWb.size() > 0 && chance(wbRate)) begin
            k = int'(randBits(6)) % pendWb.size();
            wb.valid = 1'b1;
            wb.tag = pendWb[k];
            pendWb.delete(k);
        end
        // ROB retires the oldest micro-op once its result is back
        if (robQ.size() > 0 && chance(comRate)) begin
            if (robQ[0].nmDst == '0 || rdy[robQ[0].tagDst]) begin
                commit.valid = 1'b1;
                commit.nmDst = robQ[0].nmDst;
                commit.tagDst = robQ[0].tagDst;
                lastSq = robQ[0].sqN;
                void'(robQ.pop_front());
            end
        end
        if (owed > 0 && chance(dispRate)) begin
            dispCredit = 1'b1;
            owed--;
        end
    endtask

    task automatic lookupSrc(input logic [REG_W-1:0] r, output logic [TAG_W-1:0] tag,
                             output logic avail);
        tag = (r == '0) ? '0 : specMap[r];
        avail = (r == '0) || rdy[tag] || (wb.valid && wb.tag == tag);
    endtask

    task automatic sampleOutputs();
        RenUop ren;
        DecUop d;
        logic alloc;
        alloc = 1'b0;
        if (flush.valid) begin
            check("decCredit", 128'(0), 128'(decCredit));
            check("renValid", 128'(0), 128'(renValid));
            for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                specMap[r] = comMap[r];
            end
            specIdx = 0;
            seq = flush.sqN + 1'b1;
            inQ.delete();
            expQ.delete();
            robQ.delete();
            pendWb.delete();
            decCredits = IN_DEPTH;
            dispCnt = OUT_DEPTH;
            owed = 0;
            return;
        end
        if (renValid) begin
            if (dispCnt == 0) report("renValid raised without a dispatch credit");
            dispCnt--;
            if (expQ.size() == 0) begin
                report("renValid raised with no micro-op outstanding");
            end else begin
                check("renUop", 128'(expQ[0]), 128'(renUop));
                robQ.push_back(expQ.pop_front());
                owed++;
            end
        end
        if (dispCredit) dispCnt++;
        if (decCredit) begin
            decCredits++;
            if (inQ.size() == 0) begin
                report("input buffer popped while empty");
            end else begin
                d = inQ.pop_front();
                ren.sqN = seq;
                seq = seq + 1'b1;
                lookupSrc(d.rs0, ren.tagA, ren.availA);
                lookupSrc(d.rs1, ren.tagB, ren.availB);
                ren.tagDst = '0;
                ren.nmDst = d.rd;
                ren.opcode = d.opcode;
                ren.imm = d.imm;
                if (d.rd != '0) begin
                    if (specIdx >= freeQ.size()) begin
                        report("tag allocated from an empty free list");
                    end else begin
                        ren.tagDst = freeQ[specIdx];
                        specIdx++;
                        specMap[d.rd] = ren.tagDst;
                        pendWb.push_back(ren.tagDst);
                        alloc = 1'b1;
                    end
                end
                expQ.push_back(ren);
            end
        end
        if (commit.valid && commit.nmDst != '0) begin
            freeQ.push_back(comMap[commit.nmDst]);
            void'(freeQ.pop_front());
            specIdx--;
            comMap[commit.nmDst] = commit.tagDst;
        end
        if (wb.valid) rdy[wb.tag] = 1'b1;
        if (alloc) rdy[ren.tagDst] = 1'b0;
        if (decValid) inQ.push_back(decUop);
    endtask

    task automatic runCycle(input int pushRate, input int wbRate, input int comRate,
                            input int flushRate, input int dispRate);
        @(posedge clk);
        #2;
        driveInputs(pushRate, wbRate, comRate, flushRate, dispRate);
        @(negedge clk);
        sampleOutputs();
    endtask

    // Random phase, then a drain that must empty every queue
    task automatic runTest(input string name, input int cycles, input int pushRate,
                           input int wbRate, input int comRate, input int flushRate,
                           input int dispRate);
        int n;
        curTest = name;
        testErrors = 0;
        n = 0;
        repeat (cycles) runCycle(pushRate, wbRate, comRate, flushRate, dispRate);
        while ((inQ.size() > 0 || expQ.size() > 0) && n < DRAIN_CYCLES) begin
            runCycle(0, 64, 64, 0, 64);
            n++;
        end
        if (inQ.size() > 0 || expQ.size() > 0) report("micro-ops lost after the drain");
        $display("%s: done, %0d errors", name, testErrors);
        numTests++;
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(4 * TOTAL_CYCLES * 40);
        $display("Timeout: the tests did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        lfsr = 32'hc1b3;
        {errors, checks, numTests, specIdx, owed} = '0;
        rst = 1'b1;
        {decValid, dispCredit} = '0;
        decUop = '0;
        wb = '0;
        commit = '0;
        flush = '0;
        for (int r = 0; r < NUM_ARCH_REGS; r++) begin
            specMap[r] = TAG_W'(r);
            comMap[r] = TAG_W'(r);
        end
        for (int t = 0; t < NUM_TAGS; t++) begin
            rdy[t] = (t < NUM_ARCH_REGS);
            if (t >= NUM_ARCH_REGS) freeQ.push_back(TAG_W'(t));
        end
        seq = '0;
        lastSq = '1;
        decCredits = IN_DEPTH;
        dispCnt = OUT_DEPTH;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        runTest("resetMap", 20, 48, 0, 0, 0, 64);
        runTest("renameChain", 200, 48, 16, 24, 0, 64);
        runTest("readyBits", 200, 48, 48, 24, 0, 64);
        runTest("commitRecycle", 400, 56, 48, 56, 0, 56);
        runTest("flushRestore", 300, 48, 32, 32, 3, 56);
        runTest("backPressure", 400, 56, 32, 32, 0, 4);
        $display("%0d tests, %0d checks, %0d errors", numTests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: renameTop.sv
`timescale 1ns/10ps
`default_nettype none

module renameTop (
    input logic clk,
    input logic rst,
    input logic decValid,
    input renamePkg::DecUop decUop,
    output logic decCredit,
    output logic renValid,
    output renamePkg::RenUop renUop,
    input logic dispCredit,
    input renamePkg::WbPort wb,
    input renamePkg::CommitPort commit,
    input renamePkg::FlushPort flush
);

    import renamePkg::*;

    logic inValid;
    DecUop inUop;
    logic stagePop;
    logic stagePush;
    RenUop stageUop;
    logic outCredit;
    logic [REG_W-1:0] lookupA;
    logic [REG_W-1:0] lookupB;
    logic [TAG_W-1:0] tagA;
    logic [TAG_W-1:0] tagB;
    logic availA;
    logic availB;
    logic [REG_W-1:0] allocReg;
    logic allocValid;
    logic [TAG_W-1:0] allocTag;
    logic freeEmpty;
    logic [TAG_W-1:0] prevTag;

    // Stage pop doubles as the input buffer's credit
    creditFifo #(.T(DecUop), .DEPTH(IN_DEPTH), .CONSUMER_POP(1'b1)) inBuf_i (
        .clk(clk), .rst(rst), .flush(flush.valid),
        .pushValid(decValid), .pushData(decUop), .creditOut(decCredit),
        .outValid(inValid), .outData(inUop), .creditIn(stagePop)
    );

    renameStage stage_i (
        .clk(clk), .rst(rst), .inValid(inValid), .inUop(inUop), .pop(stagePop),
        .outPush(stagePush), .outUop(stageUop), .outCredit(outCredit),
        .lookupA(lookupA), .lookupB(lookupB), .tagA(tagA), .tagB(tagB),
        .availA(availA), .availB(availB), .allocReg(allocReg),
        .allocValid(allocValid), .allocTag(allocTag), .freeEmpty(freeEmpty),
        .flush(flush)
    );

    renameTable table_i (
        .clk(clk), .rst(rst), .lookupA(lookupA), .lookupB(lookupB),
        .allocReg(allocReg), .allocValid(allocValid), .allocTag(allocTag),
        .tagA(tagA), .tagB(tagB), .availA(availA), .availB(availB),
        .wb(wb), .commit(commit), .prevTag(prevTag), .flush(flush)
    );

    tagFreeList freeList_i (
        .clk(clk), .rst(rst), .allocReq(allocValid), .allocTag(allocTag),
        .empty(freeEmpty), .commit(commit), .prevTag(prevTag), .flush(flush)
    );

    creditFifo #(.T(RenUop), .DEPTH(OUT_DEPTH), .CONSUMER_POP(1'b0)) outBuf_i (
        .clk(clk), .rst(rst), .flush(flush.valid),
        .pushValid(stagePush), .pushData(stageUop), .creditOut(outCredit),
        .outValid(renValid), .outData(renUop), .creditIn(dispCredit)
    );

endmodule

`default_nettype wire

// File: tagFreeList.sv
`timescale 1ns/10ps
`default_nettype none

module tagFreeList (
    input logic clk,
    input logic rst,
    input logic allocReq,
    output logic [renamePkg::TAG_W-1:0] allocTag,
    output logic empty,
    input renamePkg::CommitPort commit,
    input logic [renamePkg::TAG_W-1:0] prevTag,
    input renamePkg::FlushPort flush
);

    import renamePkg::*;

    logic [TAG_W-1:0] ring [NUM_TAGS];
    logic [TAG_W-1:0] specHead;
    logic [TAG_W-1:0] comHead;
    logic [TAG_W-1:0] tail;
    logic comAdvance;

    // Only commits that write a register recycle a tag
    assign comAdvance = commit.valid && (commit.nmDst != '0);

    // comHead to tail always spans 32 entries, so the ring never fills
    assign allocTag = ring[specHead];
    assign empty = (specHead == tail);

    always_ff @(posedge clk) begin
        if (rst) begin
            specHead <= '0;
            comHead <= '0;
            tail <= TAG_W'(NUM_ARCH_REGS);
        end else begin
            if (comAdvance) begin
                comHead <= comHead + 1'b1;
                tail <= tail + 1'b1;
            end
            if (flush.valid) begin
                specHead <= comAdvance ? comHead + 1'b1 : comHead;
            end else if (allocReq) begin
                specHead <= specHead + 1'b1;
            end
        end
    end

    // Initial contents are tags 32 to 63 from slot 0
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_TAGS; i++) begin
                ring[i] <= TAG_W'(NUM_ARCH_REGS + i);
            end
        end else if (comAdvance) begin
            ring[tail] <= prevTag;
        end
    end

endmodule

`default_nettype wire
